// ==== hdl/simd_pkg.sv ====
// SIMD cluster shared definitions.
// Lane data types, the opcode set, the issue command and the retire code.

package simd_pkg;

  // width of one signed lane.
  localparam int LANE_W = 16;

  // one signed lane value.
  typedef logic signed [LANE_W-1:0] lane_t;

  // lane value with one guard bit for add and subtract.
  typedef logic signed [LANE_W:0] wide_t;

  // clamp limits of a lane.
  localparam lane_t LANE_MAX = {1'b0, {(LANE_W-1){1'b1}}};
  localparam lane_t LANE_MIN = {1'b1, {(LANE_W-1){1'b0}}};

  // lane operations, signed throughout.
  typedef enum logic [2:0] {
    op_add_sat = 3'd0,
    op_sub_sat = 3'd1,
    op_min     = 3'd2,
    op_max     = 3'd3,
    op_and     = 3'd4,
    op_xor     = 3'd5
  } simd_op_e;

  // issue command.
  // fwd_a and fwd_b pick the last retired vector in place of the port.
  typedef struct packed {
    simd_op_e op;
    logic     fwd_a;
    logic     fwd_b;
  } simd_req_t;

  // retire code, merged over all lanes.
  typedef struct packed {
    logic sat;   // some lane clamped.
    logic zero;  // every lane is zero.
  } ret_t;

endpackage

// ==== hdl/simd_issue.sv ====
// SIMD issue stage.
// Runs the input four-phase handshake, captures or forwards the operands
// and starts all lanes together.

`timescale 1ns/100ps

module simd_issue
  import simd_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  // input handshake.
  input  logic                    in_req,
  input  simd_req_t               in_cmd,
  input  lane_t     [LANES-1:0]   in_a,
  input  lane_t     [LANES-1:0]   in_b,
  output logic                    in_ack,
  // from retire.
  input  logic                    slot_free,
  input  lane_t     [LANES-1:0]   last_res,
  // lane dispatch.
  output logic      [LANES-1:0]   lane_go,
  output simd_op_e                lane_op,
  output lane_t     [LANES-1:0]   lane_a,
  output lane_t     [LANES-1:0]   lane_b
);

  typedef enum logic [1:0] {
    idle,
    ack_hi,
    wait_free
  } state_e;

  state_e state_q;
  logic   freed_q;
  logic   accept;

  // a request is taken only from idle.
  assign accept = (state_q == idle) && in_req;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
      in_ack  <= 1'b0;
      lane_go <= '0;
      freed_q <= 1'b0;
    end else begin
      lane_go <= '0;
      case (state_q)
        idle: begin
          if (in_req) begin
            state_q <= ack_hi;
            in_ack  <= 1'b1;
            lane_go <= {LANES{1'b1}};
            freed_q <= 1'b0;
          end
        end
        ack_hi: begin
          // retire may finish before the source drops its request.
          if (slot_free) begin
            freed_q <= 1'b1;
          end
          if (!in_req) begin
            in_ack  <= 1'b0;
            state_q <= (freed_q || slot_free) ? idle : wait_free;
          end
        end
        wait_free: begin
          if (slot_free) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // operand capture with forwarding from the last retired vector.
  always_ff @(posedge clk) begin
    if (accept) begin
      lane_op <= in_cmd.op;
      lane_a  <= in_cmd.fwd_a ? last_res : in_a;
      lane_b  <= in_cmd.fwd_b ? last_res : in_b;
    end
  end

endmodule

// ==== hdl/simd_lane.sv ====
// SIMD lane ALU.
// Two-stage signed datapath: raw result with a guard bit first,
// then clamping to the lane range with saturation reporting.

`timescale 1ns/100ps

module simd_lane
  import simd_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     go,
  input  simd_op_e op,
  input  lane_t    a,
  input  lane_t    b,
  output logic     done,
  output lane_t    res,
  output logic     sat
);

  wide_t a_x;
  wide_t b_x;
  wide_t raw;
  wide_t wide_q;
  logic  v1_q;
  logic  ovf;

  // sign-extended operands.
  assign a_x = {a[LANE_W-1], a};
  assign b_x = {b[LANE_W-1], b};

  // stage one result.
  always_comb begin
    case (op)
      op_add_sat: raw = a_x + b_x;
      op_sub_sat: raw = a_x - b_x;
      op_min:     raw = (a < b) ? a_x : b_x;
      op_max:     raw = (a < b) ? b_x : a_x;
      op_and:     raw = a_x & b_x;
      op_xor:     raw = a_x ^ b_x;
      default:    raw = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      v1_q <= 1'b0;
    end else begin
      v1_q <= go;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      wide_q <= raw;
    end
  end

  // guard bit differs from the lane sign only on add or subtract overflow.
  assign ovf = wide_q[LANE_W] ^ wide_q[LANE_W-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= v1_q;
    end
  end

  // stage two clamp.
  always_ff @(posedge clk) begin
    if (v1_q) begin
      sat <= ovf;
      if (ovf) begin
        res <= wide_q[LANE_W] ? LANE_MIN : LANE_MAX;
      end else begin
        res <= wide_q[LANE_W-1:0];
      end
    end
  end

endmodule

// ==== hdl/simd_retire.sv ====
// SIMD retire stage.
// Collects the lane results, merges the lane flags into the retire code
// and returns the vector over the output four-phase handshake.

`timescale 1ns/100ps

module simd_retire
  import simd_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  // from the lanes.
  input  logic    [LANES-1:0]   lane_done,
  input  lane_t   [LANES-1:0]   lane_res,
  input  logic    [LANES-1:0]   lane_sat,
  // output handshake.
  output logic                  out_req,
  input  logic                  out_ack,
  output lane_t   [LANES-1:0]   out_res,
  output ret_t                  out_ret,
  // back to issue.
  output logic                  slot_free,
  output lane_t   [LANES-1:0]   last_res
);

  typedef enum logic [1:0] {
    idle,
    req_hi,
    wait_low
  } state_e;

  state_e state_q;
  logic   all_done;
  logic   all_zero;

  // lanes always finish in the same cycle.
  assign all_done = &lane_done;

  always_comb begin
    all_zero = 1'b1;
    for (int i = 0; i < LANES; i++) begin
      if (lane_res[i] != '0) begin
        all_zero = 1'b0;
      end
    end
  end

  // retired vector, zero until the first result.
  always_ff @(posedge clk) begin
    if (reset) begin
      out_res <= '0;
    end else if (all_done) begin
      out_res <= lane_res;
    end
  end

  always_ff @(posedge clk) begin
    if (all_done) begin
      out_ret.sat  <= |lane_sat;
      out_ret.zero <= all_zero;
    end
  end

  assign last_res = out_res;

  // output handshake.
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= idle;
      out_req   <= 1'b0;
      slot_free <= 1'b0;
    end else begin
      slot_free <= 1'b0;
      case (state_q)
        idle: begin
          if (all_done) begin
            state_q <= req_hi;
            out_req <= 1'b1;
          end
        end
        req_hi: begin
          if (out_ack) begin
            state_q <= wait_low;
            out_req <= 1'b0;
          end
        end
        wait_low: begin
          // slot is free once the sink has dropped its ack.
          if (!out_ack) begin
            state_q   <= idle;
            slot_free <= 1'b1;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

endmodule

// ==== hdl/simd_unit.sv ====
// SIMD execution cluster.
// Issue stage, a row of identical signed lane ALUs and the retire stage.

`timescale 1ns/100ps

module simd_unit
  import simd_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_req,
  input  simd_req_t             in_cmd,
  input  lane_t   [LANES-1:0]   in_a,
  input  lane_t   [LANES-1:0]   in_b,
  output logic                  in_ack,
  output logic                  out_req,
  input  logic                  out_ack,
  output lane_t   [LANES-1:0]   out_res,
  output ret_t                  out_ret
);

  logic     [LANES-1:0] lane_go;
  simd_op_e             lane_op;
  lane_t    [LANES-1:0] lane_a;
  lane_t    [LANES-1:0] lane_b;
  logic     [LANES-1:0] lane_done;
  lane_t    [LANES-1:0] lane_res;
  logic     [LANES-1:0] lane_sat;
  logic                 slot_free;
  lane_t    [LANES-1:0] last_res;

  simd_issue #(
    .LANES (LANES)
  ) u_issue (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .in_cmd    (in_cmd),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_ack    (in_ack),
    .slot_free (slot_free),
    .last_res  (last_res),
    .lane_go   (lane_go),
    .lane_op   (lane_op),
    .lane_a    (lane_a),
    .lane_b    (lane_b)
  );

  // one ALU per lane, all sharing the opcode.
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    simd_lane u_lane (
      .clk   (clk),
      .reset (reset),
      .go    (lane_go[i]),
      .op    (lane_op),
      .a     (lane_a[i]),
      .b     (lane_b[i]),
      .done  (lane_done[i]),
      .res   (lane_res[i]),
      .sat   (lane_sat[i])
    );
  end

  simd_retire #(
    .LANES (LANES)
  ) u_retire (
    .clk       (clk),
    .reset     (reset),
    .lane_done (lane_done),
    .lane_res  (lane_res),
    .lane_sat  (lane_sat),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_res   (out_res),
    .out_ret   (out_ret),
    .slot_free (slot_free),
    .last_res  (last_res)
  );

endmodule

// ==== tests/simd_unit_chk.sv ====
// SIMD cluster handshake checker.
// Bound into the top level to watch both four-phase handshakes.

`timescale 1ns/100ps

module simd_unit_chk
  import simd_pkg::*;
#(
  parameter int LANES = 4
) (
  input logic                clk,
  input logic                reset,
  input logic                in_req,
  input logic                in_ack,
  input logic                out_req,
  input logic                out_ack,
  input lane_t [LANES-1:0]   out_res
);

  logic accepted_q;

  // set once the first request has been acknowledged.
  always_ff @(posedge clk) begin
    if (reset) begin
      accepted_q <= 1'b0;
    end else if (in_ack) begin
      accepted_q <= 1'b1;
    end
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(in_ack) |-> $past(in_req))
    else $error("in_ack rose while in_req was low");

  res_stable: assert property (@(posedge clk) disable iff (reset)
    (out_req && !out_ack) |=> $stable(out_res))
    else $error("out_res changed while out_req waited for out_ack");

  no_early_req: assert property (@(posedge clk) disable iff (reset)
    !accepted_q |-> !out_req)
    else $error("out_req rose before any request was accepted");

endmodule

bind simd_unit simd_unit_chk #(
  .LANES (LANES)
) u_chk (
  .clk     (clk),
  .reset   (reset),
  .in_req  (in_req),
  .in_ack  (in_ack),
  .out_req (out_req),
  .out_ack (out_ack),
  .out_res (out_res)
);

// ==== tests/simd_unit_tb.sv ====
// SIMD cluster testbench.
// Directed tests against a lane reference model, with both four-phase
// handshakes driven by tasks and a cycle watchdog.

`timescale 1ns/100ps

module simd_unit_tb
  import simd_pkg::*;
();

  localparam int LANES   = 4;
  localparam int N_OPS   = 37;
  localparam int TIMEOUT = 40 * N_OPS + 100;

  typedef lane_t [LANES-1:0] vec_t;

  logic      clk;
  logic      reset;
  logic      in_req;
  simd_req_t in_cmd;
  vec_t      in_a;
  vec_t      in_b;
  logic      in_ack;
  logic      out_req;
  logic      out_ack;
  vec_t      out_res;
  ret_t      out_ret;

  int   errors = 0;
  int   checks = 0;
  int   cycles = 0;
  vec_t model_prev = '0;
  vec_t got_res;
  ret_t got_ret;

  simd_unit #(
    .LANES (LANES)
  ) u_simd_unit (
    .clk     (clk),
    .reset   (reset),
    .in_req  (in_req),
    .in_cmd  (in_cmd),
    .in_a    (in_a),
    .in_b    (in_b),
    .in_ack  (in_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_res (out_res),
    .out_ret (out_ret)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [LANE_W-1:0] exp,
                           input logic [LANE_W-1:0] got);
    checks++;
    assert (got == exp)
    else begin
      errors++;
      $display("error %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_vec(input string name, input vec_t exp, input vec_t got);
    for (int i = 0; i < LANES; i++) begin
      check_val($sformatf("%s[%0d]", name, i), exp[i], got[i]);
    end
  endtask

  function automatic vec_t make_vec(int base, int stride);
    vec_t v;
    for (int i = 0; i < LANES; i++) begin
      v[i] = lane_t'(base + i * stride);
    end
    return v;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int i = 0; i < LANES; i++) begin
      v[i] = lane_t'($urandom);
    end
    return v;
  endfunction

  function automatic simd_req_t make_cmd(simd_op_e opc, logic fa, logic fb);
    return '{op: opc, fwd_a: fa, fwd_b: fb};
  endfunction

  // one lane of the model, saturation bit on top.
  function automatic logic [LANE_W:0] model_lane(simd_op_e op, lane_t a, lane_t b);
    int hi;
    int lo;
    int v;
    hi = (1 << (LANE_W - 1)) - 1;
    lo = -(1 << (LANE_W - 1));
    case (op)
      op_add_sat: v = int'(a) + int'(b);
      op_sub_sat: v = int'(a) - int'(b);
      op_min:     v = (a < b) ? int'(a) : int'(b);
      op_max:     v = (a > b) ? int'(a) : int'(b);
      op_and:     v = int'(a & b);
      default:    v = int'(a ^ b);
    endcase
    if (v > hi) begin
      return {1'b1, lane_t'(hi)};
    end
    if (v < lo) begin
      return {1'b1, lane_t'(lo)};
    end
    return {1'b0, lane_t'(v)};
  endfunction

  // whole vector, with forwarding from the previous model result.
  task automatic predict(input simd_req_t cmd, input vec_t a, input vec_t b,
                         output vec_t res, output ret_t ret);
    logic [LANE_W:0] r;
    ret = '{sat: 1'b0, zero: 1'b1};
    for (int i = 0; i < LANES; i++) begin
      r = model_lane(cmd.op, cmd.fwd_a ? model_prev[i] : a[i],
                     cmd.fwd_b ? model_prev[i] : b[i]);
      res[i] = r[LANE_W-1:0];
      ret.sat = ret.sat | r[LANE_W];
      if (res[i] != '0) begin
        ret.zero = 1'b0;
      end
    end
    model_prev = res;
  endtask

  task automatic finish_req();
    while (!in_ack) step();
    in_req = 1'b0;
    while (in_ack) step();
  endtask

  task automatic send_op(input simd_req_t cmd, input vec_t a, input vec_t b);
    in_cmd = cmd;
    in_a   = a;
    in_b   = b;
    in_req = 1'b1;
    finish_req();
  endtask

  // issue stays blocked for the whole output handshake.
  task automatic get_result(input int delay);
    while (!out_req) step();
    got_res = out_res;
    got_ret = out_ret;
    repeat (delay) begin
      step();
      check_vec("out_res", got_res, out_res);
      check_val("in_ack", '0, LANE_W'(in_ack));
    end
    out_ack = 1'b1;
    while (out_req) begin
      step();
      check_val("in_ack", '0, LANE_W'(in_ack));
    end
    out_ack = 1'b0;
  endtask

  task automatic run_op(input simd_req_t cmd, input vec_t a, input vec_t b);
    vec_t exp_res;
    ret_t exp_ret;
    predict(cmd, a, b, exp_res, exp_ret);
    send_op(cmd, a, b);
    get_result(0);
    check_vec("out_res", exp_res, got_res);
    check_val("out_ret", LANE_W'(exp_ret), LANE_W'(got_ret));
  endtask

  task automatic sat_case(input simd_op_e op, input vec_t a, input vec_t b,
                          input logic exp_sat, input logic exp_zero);
    run_op(make_cmd(op, 1'b0, 1'b0), a, b);
    check_val("out_ret.sat", LANE_W'(exp_sat), LANE_W'(got_ret.sat));
    check_val("out_ret.zero", LANE_W'(exp_zero), LANE_W'(got_ret.zero));
  endtask

  task automatic test_idle();
    repeat (8) begin
      step();
      check_val("in_ack", '0, LANE_W'(in_ack));
      check_val("out_req", '0, LANE_W'(out_req));
    end
  endtask

  task automatic test_opcodes();
    for (int n = 0; n < 3; n++) begin
      for (int k = 0; k < 6; k++) begin
        run_op(make_cmd(simd_op_e'(k), 1'b0, 1'b0), rand_vec(), rand_vec());
      end
    end
  endtask

  task automatic test_saturation();
    vec_t v;
    v = rand_vec();
    sat_case(op_add_sat, make_vec(32000, 100), make_vec(1000, 0), 1'b1, 1'b0);
    sat_case(op_add_sat, make_vec(-32000, -100), make_vec(-1000, 0), 1'b1, 1'b0);
    sat_case(op_add_sat, make_vec(32700, 30), make_vec(30, 0), 1'b1, 1'b0);
    sat_case(op_sub_sat, make_vec(32000, 50), make_vec(-2000, 0), 1'b1, 1'b0);
    sat_case(op_sub_sat, make_vec(-32000, -50), make_vec(2000, 0), 1'b1, 1'b0);
    sat_case(op_add_sat, make_vec(1000, 123), make_vec(-3000, 77), 1'b0, 1'b0);
    sat_case(op_sub_sat, make_vec(-500, 9), make_vec(700, -13), 1'b0, 1'b0);
    sat_case(op_sub_sat, v, v, 1'b0, 1'b1);
    sat_case(op_xor, v, v, 1'b0, 1'b1);
  endtask

  // forwarded ports carry random garbage.
  task automatic test_forwarding();
    run_op(make_cmd(op_max, 1'b0, 1'b0), rand_vec(), rand_vec());
    run_op(make_cmd(op_add_sat, 1'b1, 1'b0), rand_vec(), rand_vec());
    run_op(make_cmd(op_sub_sat, 1'b0, 1'b1), rand_vec(), rand_vec());
    run_op(make_cmd(op_and, 1'b1, 1'b1), rand_vec(), rand_vec());
  endtask

  task automatic test_backpressure();
    simd_req_t cmd1;
    simd_req_t cmd2;
    vec_t      a;
    vec_t      b;
    vec_t      exp1;
    vec_t      exp2;
    ret_t      ret1;
    ret_t      ret2;
    for (int n = 0; n < 3; n++) begin
      cmd1 = make_cmd(simd_op_e'(n), 1'b0, 1'b0);
      a = rand_vec();
      b = rand_vec();
      predict(cmd1, a, b, exp1, ret1);
      send_op(cmd1, a, b);
      // second request waits behind the stalled result.
      cmd2 = make_cmd(op_add_sat, 1'b1, 1'b0);
      in_cmd = cmd2;
      in_a   = rand_vec();
      in_b   = rand_vec();
      predict(cmd2, in_a, in_b, exp2, ret2);
      in_req = 1'b1;
      get_result(int'($urandom_range(20, 5)));
      check_vec("out_res", exp1, got_res);
      check_val("out_ret", LANE_W'(ret1), LANE_W'(got_ret));
      finish_req();
      get_result(0);
      check_vec("out_res", exp2, got_res);
      check_val("out_ret", LANE_W'(ret2), LANE_W'(got_ret));
    end
  endtask

  initial begin
    void'($urandom(32'hb4fa_2cbf));
    clk     = 1'b0;
    reset   = 1'b1;
    in_req  = 1'b0;
    in_cmd  = '0;
    in_a    = '0;
    in_b    = '0;
    out_ack = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    test_idle();
    test_opcodes();
    test_saturation();
    test_forwarding();
    test_backpressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/simd_pkg.sv
hdl/simd_issue.sv
hdl/simd_lane.sv
hdl/simd_retire.sv
hdl/simd_unit.sv
tests/simd_unit_chk.sv
tests/simd_unit_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module simd_unit_tb \
		-f filelist.f -Mdir obj_dir -o simd_unit_tb
	./obj_dir/simd_unit_tb | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
